// ==== Bender.yml ====
package:
  name: ipod_player

sources:
  - hw/ipod_pkg.sv
  - hw/player_ctrl.sv
  - hw/speed_keys.sv
  - hw/sample_rate_gen.sv
  - hw/flash_fetch.sv
  - hw/sample_unpack.sv
  - hw/hex_display.sv
  - hw/ipod_top.sv
  - target: test
    files:
      - bench/flash_model.sv
      - bench/tb_ipod.sv

// ==== bench/flash_model.sv ====
`timescale 1ns/10ps

module flash_model import ipod_pkg::*; (
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  flash_req_t flash_req,
  output flash_rsp_t flash_rsp
);

  integer            seed = 35;
  int                wait_left;
  int                lat_left;
  logic              busy;
  logic [ADDR_W-1:0] addr_q;
  logic              rd_valid;
  logic [DATA_W-1:0] rd_data;

  // Address byte on top, its inverse in bits 15:8
  function automatic logic [DATA_W-1:0] word_at(input logic [ADDR_W-1:0] addr);
    logic [7:0] lo;
    lo = addr[7:0];
    return {lo, 8'h00, ~lo, 8'h00};
  endfunction

  function automatic int random_below(input int span);
    return $unsigned($random(seed)) % span;
  endfunction

  // ==============================
  // Wait states and read latency
  // ==============================
  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wait_left <= random_below(6);
      lat_left  <= 0;
      busy      <= 1'b0;
      addr_q    <= '0;
      rd_valid  <= 1'b0;
      rd_data   <= '0;
    end
    else
    begin
      rd_valid <= 1'b0;
      if (busy)
      begin
        if (lat_left <= 1)
        begin
          rd_valid <= 1'b1;
          rd_data  <= word_at(addr_q);
          busy     <= 1'b0;
        end
        else
          lat_left <= lat_left - 1;
      end
      else if (flash_req.read)
      begin
        if (wait_left > 0)
          wait_left <= wait_left - 1;
        else
        begin
          // Accepted, draw the wait for the next request
          addr_q    <= flash_req.address;
          lat_left  <= 1 + random_below(3);
          wait_left <= random_below(6);
          busy      <= 1'b1;
        end
      end
    end
  end

  assign flash_rsp.waitrequest   = busy || wait_left != 0;
  assign flash_rsp.readdatavalid = rd_valid;
  assign flash_rsp.readdata      = rd_data;

endmodule

// ==== bench/tb_ipod.sv ====
`timescale 1ns/10ps

module tb_ipod import ipod_pkg::*; ();

  localparam int BASE_P    = 40;
  localparam int STEP_P    = 8;
  localparam int MIN_P     = 16;
  localparam int MAX_P     = 64;
  localparam int REPEAT_P  = 200;
  localparam int DISPLAY_P = 50;
  localparam int LAST_A    = 15;
  // Cycles after a key release until the period is final
  localparam int SETTLE    = 5;

  typedef struct packed {
    logic [7:0] ascii;
    logic [2:0] keys;
    int         hold;
    int         quiet;
    int         strobes;
    logic       exp_dir;
    int         exp_addr;
    int         exp_period;
  } step_t;

  logic                CLK_50M;
  logic                arst_n;
  logic [7:0]          kbd_ascii;
  logic                kbd_strobe;
  logic [2:0]          key_n;
  flash_req_t          flash_req;
  flash_rsp_t          flash_rsp;
  logic [SAMPLE_W-1:0] audio_out;
  logic                audio_strobe;
  logic [5:0][6:0]     hex;

  step_t steps[$];

  // Reference player
  int m_addr;
  bit m_half;
  bit m_word_dir;
  bit m_dir;
  bit m_playing;

  int cycle_no;
  int last_strobe;
  int strobe_count;
  bit gap_armed;
  int gap_exp;
  int watchdog_cycles;

  ipod_top #(
    .BASE_PERIOD    (BASE_P),
    .PERIOD_STEP    (STEP_P),
    .MIN_PERIOD     (MIN_P),
    .MAX_PERIOD     (MAX_P),
    .REPEAT_CYCLES  (REPEAT_P),
    .DISPLAY_CYCLES (DISPLAY_P),
    .LAST_ADDR      (ADDR_W'(LAST_A))
  ) UUT (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .kbd_ascii    (kbd_ascii),
    .kbd_strobe   (kbd_strobe),
    .key_n        (key_n),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .audio_out    (audio_out),
    .audio_strobe (audio_strobe),
    .hex          (hex)
  );

  flash_model u_flash (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  always #10 CLK_50M = ~CLK_50M;

  // ==============================
  // Reference rules
  // ==============================
  // Lit segments gfedcba, inverted for the active-low display
  function automatic logic [6:0] seg_pattern(input logic [3:0] nib);
    logic [6:0] lit;
    case (nib)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  // Forward words play bits 15:8 first, backward words bits 31:24 first
  function automatic logic [7:0] expected_sample(input int addr, input bit half,
                                                 input bit word_dir);
    logic [7:0] a;
    bit         upper;
    a = addr[7:0];
    if (word_dir)
      upper = (half == 1'b0);
    else
      upper = (half == 1'b1);
    return upper ? a : ~a;
  endfunction

  function automatic int next_addr(input int addr, input bit backward);
    if (backward)
      return (addr == 0) ? LAST_A : addr - 1;
    else
      return (addr == LAST_A) ? 0 : addr + 1;
  endfunction

  function automatic int clamp_period(input int p);
    if (p < MIN_P)
      return MIN_P;
    else if (p > MAX_P)
      return MAX_P;
    else
      return p;
  endfunction

  function automatic logic [7:0] lower_case(input logic [7:0] c);
    if (c >= "A" && c <= "Z")
      return c + 8'd32;
    else
      return c;
  endfunction

  // ==============================
  // Error reporting
  // ==============================
  task automatic report_mismatch(input string name, input int got, input int exp_val);
    $display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp_val);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  // One clock cycle, checking any sample seen at the falling edge
  task automatic cycle_check();
    logic [7:0] exp_val;
    @(negedge CLK_50M);
    cycle_no++;
    if (audio_strobe)
    begin
      assert (m_playing)
      else report_error("audio_strobe pulsed while the player was paused");
      exp_val = expected_sample(m_addr, m_half, m_word_dir);
      assert (audio_out == exp_val)
      else report_mismatch("audio_out", audio_out, exp_val);
      if (gap_armed)
      begin
        assert (cycle_no - last_strobe == gap_exp)
        else report_mismatch("audio_strobe spacing", cycle_no - last_strobe, gap_exp);
      end
      last_strobe = cycle_no;
      strobe_count++;
      if (m_half)
      begin
        m_addr     = next_addr(m_addr, m_dir);
        m_word_dir = m_dir;
      end
      m_half = !m_half;
    end
  endtask

  task automatic send_byte(input logic [7:0] c);
    logic [7:0] lc;
    lc         = lower_case(c);
    kbd_ascii  = c;
    kbd_strobe = 1'b1;
    if (lc == "e")
      m_playing = 1'b1;
    else if (lc == "d")
      m_playing = 1'b0;
    cycle_check();
    kbd_strobe = 1'b0;
    // A load in the strobe cycle still uses the old direction
    if (lc == "f")
      m_dir = 1'b0;
    else if (lc == "b")
      m_dir = 1'b1;
    else if (lc == "r")
    begin
      m_addr     = m_dir ? LAST_A : 0;
      m_half     = 1'b0;
      m_word_dir = m_dir;
    end
  endtask

  task automatic hold_keys(input logic [2:0] keys, input int cycles);
    key_n = ~keys;
    repeat (cycles) cycle_check();
    key_n = 3'b111;
    repeat (SETTLE) cycle_check();
  endtask

  task automatic collect(input int n, input int period);
    int got;
    int seen;
    got       = 0;
    gap_armed = 1'b0;
    gap_exp   = period;
    while (got < n)
    begin
      seen = strobe_count;
      cycle_check();
      if (strobe_count != seen)
      begin
        got++;
        gap_armed = 1'b1;
      end
    end
    gap_armed = 1'b0;
  endtask

  task automatic check_hex(input int period);
    logic [6:0] exp_val;
    for (int i = 0; i < 6; i++)
    begin
      exp_val = seg_pattern(4'((period >> (4 * i)) & 15));
      assert (hex[i] == exp_val)
      else report_mismatch($sformatf("hex[%0d]", i), hex[i], exp_val);
    end
  endtask

  // ==============================
  // Stimulus table
  // ==============================
  task automatic add_step(input logic [7:0] ascii, input logic [2:0] keys,
                          input int hold, input int quiet, input int strobes,
                          input logic exp_dir, input int exp_addr, input int exp_period);
    step_t s;
    s.ascii      = ascii;
    s.keys       = keys;
    s.hold       = hold;
    s.quiet      = quiet;
    s.strobes    = strobes;
    s.exp_dir    = exp_dir;
    s.exp_addr   = exp_addr;
    s.exp_period = exp_period;
    steps.push_back(s);
    watchdog_cycles += hold + SETTLE + quiet + (strobes + 2) * MAX_P + DISPLAY_P + 4;
  endtask

  task automatic run_step(input step_t s);
    if (s.ascii != 8'h00)
    begin
      send_byte(s.ascii);
      // Start point only known for keyboard steps
      assert (m_addr == s.exp_addr)
      else report_mismatch("start address", m_addr, s.exp_addr);
      assert (m_dir == s.exp_dir)
      else report_mismatch("direction", m_dir, s.exp_dir);
    end
    if (s.keys != 3'b000)
      hold_keys(s.keys, s.hold);
    repeat (s.quiet) cycle_check();
    collect(s.strobes, s.exp_period);
    repeat (DISPLAY_P + 2) cycle_check();
    check_hex(s.exp_period);
  endtask

  initial
  begin
    CLK_50M      = 1'b0;
    arst_n       = 1'b0;
    kbd_ascii    = 8'h00;
    kbd_strobe   = 1'b0;
    key_n        = 3'b111;
    m_addr       = 0;
    m_half       = 1'b0;
    m_word_dir   = 1'b0;
    m_dir        = 1'b0;
    m_playing    = 1'b0;
    cycle_no     = 0;
    last_strobe  = 0;
    strobe_count = 0;
    gap_armed    = 1'b0;
    gap_exp      = 0;

    // Forward from 0 through the wrap, paused on a half B
    add_step("E", 3'b000, 0, 0, 40, 1'b0, 0, BASE_P);
    add_step("D", 3'b000, 0, 5 * BASE_P, 0, 1'b0, 4, BASE_P);
    add_step("e", 3'b000, 0, 0, 5, 1'b0, 4, BASE_P);
    add_step("B", 3'b000, 0, 0, 20, 1'b1, 7, BASE_P);
    add_step("R", 3'b000, 0, 0, 6, 1'b1, LAST_A, BASE_P);
    add_step("f", 3'b000, 0, 0, 6, 1'b0, 12, BASE_P);
    add_step("z", 3'b000, 0, 0, 4, 1'b0, 0, BASE_P);
    add_step(8'h00, 3'b001, 4 * REPEAT_P, 0, 8, 1'b0, 0,
             clamp_period(BASE_P - 4 * STEP_P));
    add_step(8'h00, 3'b010, REPEAT_P, 0, 6, 1'b0, 0, clamp_period(MIN_P + STEP_P));
    add_step(8'h00, 3'b100, 10, 0, 6, 1'b0, 0, BASE_P);
    watchdog_cycles += 8 + 60 + 500;

    repeat (8) @(posedge CLK_50M);
    @(negedge CLK_50M);
    arst_n = 1'b1;

    // Idle after reset
    repeat (60)
    begin
      cycle_check();
      assert (!flash_req.read)
      else report_error("flash read raised before play was pressed");
    end
    assert (audio_out == 8'h00)
    else report_mismatch("audio_out", audio_out, 0);
    check_hex(BASE_P);

    foreach (steps[i])
      run_step(steps[i]);

    $display("Regression passed");
    $finish;
  end

  // Watchdog
  initial
  begin
    @(posedge arst_n);
    repeat (watchdog_cycles) @(posedge CLK_50M);
    report_error($sformatf("timeout, the test table did not finish in %0d cycles",
                           watchdog_cycles));
  end

endmodule

// ==== hw/flash_fetch.sv ====
`timescale 1ns/10ps

module flash_fetch import ipod_pkg::*; #(
  parameter logic [ADDR_W-1:0] LAST_ADDR = DEF_LAST_ADDR
) (
  input  logic              CLK_50M,
  input  logic              arst_n,
  input  logic              fetch_start,
  input  logic              step,
  input  logic              dir,
  input  logic              restart,
  output flash_req_t        flash_req,
  input  flash_rsp_t        flash_rsp,
  output logic [DATA_W-1:0] word,
  output logic              word_valid
);

  logic [ADDR_W-1:0] addr;
  logic [ADDR_W-1:0] addr_next;
  logic              rd_req;
  logic              pending;

  // ==============================
  // Word address
  // ==============================
  // dir high means backward
  always_comb
  begin
    addr_next = addr;
    if (restart)
      addr_next = dir ? LAST_ADDR : '0;
    else if (step)
    begin
      if (dir)
        addr_next = (addr == '0) ? LAST_ADDR : addr - 1'b1;
      else
        addr_next = (addr == LAST_ADDR) ? '0 : addr + 1'b1;
    end
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      addr <= '0;
    else
      addr <= addr_next;
  end

  // ==============================
  // Read handshake
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_req  <= 1'b0;
      pending <= 1'b0;
    end
    else
    begin
      // Held through wait states, dropped once accepted
      if (fetch_start)
        rd_req <= 1'b1;
      else if (rd_req && !flash_rsp.waitrequest)
        rd_req <= 1'b0;

      if (fetch_start)
        pending <= 1'b1;
      else if (flash_rsp.readdatavalid)
        pending <= 1'b0;
    end
  end

  assign flash_req.read    = rd_req;
  assign flash_req.address = addr;

  assign word_valid = pending && flash_rsp.readdatavalid;

  always_ff @(posedge CLK_50M)
  begin
    if (word_valid)
      word <= flash_rsp.readdata;
  end

  a_req_stable: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_req.read && flash_rsp.waitrequest |=>
      flash_req.read && $stable(flash_req.address));

endmodule

// ==== hw/hex_display.sv ====
`timescale 1ns/10ps

module hex_display import ipod_pkg::*; #(
  parameter int unsigned DISPLAY_CYCLES = DEF_DISPLAY_CYCLES
) (
  input  logic                CLK_50M,
  input  logic                arst_n,
  input  logic [PERIOD_W-1:0] period,
  output logic [5:0][6:0]     hex
);

  localparam int CNT_W = $clog2(DISPLAY_CYCLES + 1);

  logic [CNT_W-1:0] refresh_cnt;
  logic [23:0]      shown;

  // Active low, segment a in bit 0
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    logic [6:0] seg;
    case (nib)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'hA: seg = 7'h08;
      4'hB: seg = 7'h03;
      4'hC: seg = 7'h46;
      4'hD: seg = 7'h21;
      4'hE: seg = 7'h06;
      default: seg = 7'h0E;
    endcase
    return seg;
  endfunction

  // Counter starts at zero so the first latch follows reset directly
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      refresh_cnt <= '0;
      shown       <= '0;
    end
    else if (refresh_cnt == '0)
    begin
      refresh_cnt <= CNT_W'(DISPLAY_CYCLES - 1);
      shown       <= 24'(period);
    end
    else
      refresh_cnt <= refresh_cnt - 1'b1;
  end

  for (genvar i = 0; i < 6; i++)
  begin : g_digit
    assign hex[i] = seg7(shown[4*i +: 4]);
  end

endmodule

// ==== hw/ipod_pkg.sv ====
package ipod_pkg;

  // ==============================
  // Bus widths
  // ==============================
  localparam int ADDR_W   = 23;
  localparam int DATA_W   = 32;
  localparam int SAMPLE_W = 8;
  localparam int PERIOD_W = 16;

  // ==============================
  // Top-level parameter defaults
  // ==============================
  // 50 MHz / 1136 is roughly 44 kHz
  localparam int unsigned DEF_BASE_PERIOD    = 1136;
  localparam int unsigned DEF_PERIOD_STEP    = 100;
  localparam int unsigned DEF_MIN_PERIOD     = 400;
  localparam int unsigned DEF_MAX_PERIOD     = 4000;
  // Ten speed events per second while a key is held
  localparam int unsigned DEF_REPEAT_CYCLES  = 5_000_000;
  // Display refresh at 2 Hz
  localparam int unsigned DEF_DISPLAY_CYCLES = 25_000_000;
  localparam logic [ADDR_W-1:0] DEF_LAST_ADDR = 23'h7FFFF;

  // ==============================
  // Flash read port
  // ==============================
  typedef struct packed {
    logic              read;
    logic [ADDR_W-1:0] address;
  } flash_req_t;

  typedef struct packed {
    logic              waitrequest;
    logic              readdatavalid;
    logic [DATA_W-1:0] readdata;
  } flash_rsp_t;

  // One-cycle speed events
  typedef struct packed {
    logic up;
    logic down;
    logic rst;
  } speed_cmd_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_HALF_A,
    ST_HALF_B
  } player_state_e;

  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_PLAY,
    CMD_PAUSE,
    CMD_FWD,
    CMD_BACK,
    CMD_RESTART
  } player_cmd_e;

endpackage

// ==== hw/ipod_top.sv ====
`timescale 1ns/10ps

module ipod_top import ipod_pkg::*; #(
  parameter int unsigned        BASE_PERIOD    = DEF_BASE_PERIOD,
  parameter int unsigned        PERIOD_STEP    = DEF_PERIOD_STEP,
  parameter int unsigned        MIN_PERIOD     = DEF_MIN_PERIOD,
  parameter int unsigned        MAX_PERIOD     = DEF_MAX_PERIOD,
  parameter int unsigned        REPEAT_CYCLES  = DEF_REPEAT_CYCLES,
  parameter int unsigned        DISPLAY_CYCLES = DEF_DISPLAY_CYCLES,
  parameter logic [ADDR_W-1:0]  LAST_ADDR      = DEF_LAST_ADDR
) (
  input  logic                CLK_50M,
  input  logic                arst_n,
  input  logic [7:0]          kbd_ascii,
  input  logic                kbd_strobe,
  input  logic [2:0]          key_n,
  output flash_req_t          flash_req,
  input  flash_rsp_t          flash_rsp,
  output logic [SAMPLE_W-1:0] audio_out,
  output logic                audio_strobe,
  output logic [5:0][6:0]     hex
);

  // Controller to datapath
  logic fetch_start;
  logic word_valid;
  logic step;
  logic dir;
  logic restart;
  logic load;
  logic half_sel;
  logic sample_tick;

  speed_cmd_t          speed_cmd;
  logic [PERIOD_W-1:0] period;
  logic [DATA_W-1:0]   word;

  player_ctrl u_ctrl (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .kbd_ascii   (kbd_ascii),
    .kbd_strobe  (kbd_strobe),
    .sample_tick (sample_tick),
    .word_valid  (word_valid),
    .fetch_start (fetch_start),
    .step        (step),
    .dir         (dir),
    .restart     (restart),
    .load        (load),
    .half_sel    (half_sel)
  );

  speed_keys #(
    .REPEAT_CYCLES (REPEAT_CYCLES)
  ) u_keys (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .key_n     (key_n),
    .speed_cmd (speed_cmd)
  );

  sample_rate_gen #(
    .BASE_PERIOD (BASE_PERIOD),
    .PERIOD_STEP (PERIOD_STEP),
    .MIN_PERIOD  (MIN_PERIOD),
    .MAX_PERIOD  (MAX_PERIOD)
  ) u_rate (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .speed_cmd   (speed_cmd),
    .period      (period),
    .sample_tick (sample_tick)
  );

  flash_fetch #(
    .LAST_ADDR (LAST_ADDR)
  ) u_fetch (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .fetch_start (fetch_start),
    .step        (step),
    .dir         (dir),
    .restart     (restart),
    .flash_req   (flash_req),
    .flash_rsp   (flash_rsp),
    .word        (word),
    .word_valid  (word_valid)
  );

  sample_unpack u_unpack (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .word         (word),
    .load         (load),
    .half_sel     (half_sel),
    .audio_out    (audio_out),
    .audio_strobe (audio_strobe)
  );

  hex_display #(
    .DISPLAY_CYCLES (DISPLAY_CYCLES)
  ) u_hex (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .period  (period),
    .hex     (hex)
  );

endmodule

// ==== hw/player_ctrl.sv ====
`timescale 1ns/10ps

module player_ctrl import ipod_pkg::*; (
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  logic [7:0] kbd_ascii,
  input  logic       kbd_strobe,
  input  logic       sample_tick,
  input  logic       word_valid,
  output logic       fetch_start,
  output logic       step,
  output logic       dir,
  output logic       restart,
  output logic       load,
  output logic       half_sel
);

  player_cmd_e   cmd;
  player_state_e state;
  player_state_e state_next;

  logic playing;
  logic backward;
  logic word_dir;
  logic restart_pend;
  logic run;
  logic restart_req;
  logic restart_go;

  // ==============================
  // Keyboard decode
  // ==============================
  // Setting bit 5 folds upper case onto lower case
  always_comb
  begin
    cmd = CMD_NONE;
    if (kbd_strobe)
    begin
      case (kbd_ascii | 8'h20)
        "e":     cmd = CMD_PLAY;
        "d":     cmd = CMD_PAUSE;
        "f":     cmd = CMD_FWD;
        "b":     cmd = CMD_BACK;
        "r":     cmd = CMD_RESTART;
        default: cmd = CMD_NONE;
      endcase
    end
  end

  // Pause takes effect in the same cycle as its strobe
  assign run = (playing || cmd == CMD_PLAY) && cmd != CMD_PAUSE;

  // A restart waits until no read is outstanding
  assign restart_req = restart_pend || cmd == CMD_RESTART;
  assign restart_go  = restart_req && state != ST_FETCH;

  assign load = sample_tick && run && !restart_go &&
                (state == ST_HALF_A || state == ST_HALF_B);
  assign step = load && state == ST_HALF_B;

  assign fetch_start = restart_go || step || (state == ST_IDLE && run);
  assign restart     = restart_go;
  assign dir         = backward;

  // 1 selects the top byte of the word
  assign half_sel = (state == ST_HALF_B) ^ word_dir;

  // ==============================
  // Sequencer
  // ==============================
  always_comb
  begin
    state_next = state;
    if (fetch_start)
      state_next = ST_FETCH;
    else
    begin
      case (state)
        ST_FETCH:  if (word_valid) state_next = ST_HALF_A;
        ST_HALF_A: if (load) state_next = ST_HALF_B;
        default:   state_next = state;
      endcase
    end
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= ST_IDLE;
      playing      <= 1'b0;
      backward     <= 1'b0;
      word_dir     <= 1'b0;
      restart_pend <= 1'b0;
    end
    else
    begin
      state        <= state_next;
      playing      <= run;
      restart_pend <= restart_req && !restart_go;
      if (cmd == CMD_FWD)
        backward <= 1'b0;
      else if (cmd == CMD_BACK)
        backward <= 1'b1;
      // Half order follows the direction the word was fetched in
      if (fetch_start)
        word_dir <= backward;
    end
  end

  // One read in flight at a time
  a_single_fetch: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    fetch_start |=> (!fetch_start throughout word_valid [->1]));

endmodule

// ==== hw/sample_rate_gen.sv ====
`timescale 1ns/10ps

module sample_rate_gen import ipod_pkg::*; #(
  parameter int unsigned BASE_PERIOD = DEF_BASE_PERIOD,
  parameter int unsigned PERIOD_STEP = DEF_PERIOD_STEP,
  parameter int unsigned MIN_PERIOD  = DEF_MIN_PERIOD,
  parameter int unsigned MAX_PERIOD  = DEF_MAX_PERIOD
) (
  input  logic                CLK_50M,
  input  logic                arst_n,
  input  speed_cmd_t          speed_cmd,
  output logic [PERIOD_W-1:0] period,
  output logic                sample_tick
);

  logic [PERIOD_W-1:0] tick_cnt;

  // ==============================
  // Period register
  // ==============================
  // Up shortens the period, down lengthens it
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      period <= PERIOD_W'(BASE_PERIOD);
    else if (speed_cmd.rst)
      period <= PERIOD_W'(BASE_PERIOD);
    else if (speed_cmd.up)
    begin
      if (period < MIN_PERIOD + PERIOD_STEP)
        period <= PERIOD_W'(MIN_PERIOD);
      else
        period <= period - PERIOD_W'(PERIOD_STEP);
    end
    else if (speed_cmd.down)
    begin
      if (period + PERIOD_STEP > MAX_PERIOD)
        period <= PERIOD_W'(MAX_PERIOD);
      else
        period <= period + PERIOD_W'(PERIOD_STEP);
    end
  end

  // Tick on the last count of each period
  assign sample_tick = tick_cnt >= period - 1'b1;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      tick_cnt <= '0;
    else if (sample_tick)
      tick_cnt <= '0;
    else
      tick_cnt <= tick_cnt + 1'b1;
  end

  a_period_bounds: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    period >= MIN_PERIOD && period <= MAX_PERIOD);

endmodule

// ==== hw/sample_unpack.sv ====
`timescale 1ns/10ps

module sample_unpack import ipod_pkg::*; (
  input  logic                CLK_50M,
  input  logic                arst_n,
  input  logic [DATA_W-1:0]   word,
  input  logic                load,
  input  logic                half_sel,
  output logic [SAMPLE_W-1:0] audio_out,
  output logic                audio_strobe
);

  logic [SAMPLE_W-1:0] sample;

  // Upper byte of the top or bottom 16-bit sample
  assign sample = half_sel ? word[DATA_W-1 -: SAMPLE_W]
                           : word[DATA_W/2-1 -: SAMPLE_W];

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      audio_out    <= '0;
      audio_strobe <= 1'b0;
    end
    else
    begin
      audio_strobe <= load;
      if (load)
        audio_out <= sample;
    end
  end

endmodule

// ==== hw/speed_keys.sv ====
`timescale 1ns/10ps

module speed_keys import ipod_pkg::*; #(
  parameter int unsigned REPEAT_CYCLES = DEF_REPEAT_CYCLES
) (
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  logic [2:0] key_n,
  output speed_cmd_t speed_cmd
);

  localparam int CNT_W = $clog2(REPEAT_CYCLES + 1);

  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic             rst_key_d;
  logic [CNT_W-1:0] repeat_cnt;
  logic             rollover;

  assign rollover = repeat_cnt == CNT_W'(REPEAT_CYCLES - 1);

  // Two-flop synchronizer, keys inverted to active high
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_meta  <= '0;
      key_sync  <= '0;
      rst_key_d <= 1'b0;
    end
    else
    begin
      key_meta  <= ~key_n;
      key_sync  <= key_meta;
      rst_key_d <= key_sync[2];
    end
  end

  // Free-running repeat interval
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      repeat_cnt <= '0;
    else if (rollover)
      repeat_cnt <= '0;
    else
      repeat_cnt <= repeat_cnt + 1'b1;
  end

  // ==============================
  // Event pulses
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      speed_cmd <= '0;
    else
    begin
      speed_cmd.up   <= rollover && key_sync[0];
      speed_cmd.down <= rollover && key_sync[1];
      // Press edge of the speed reset key
      speed_cmd.rst  <= key_sync[2] && !rst_key_d;
    end
  end

endmodule

// ==== sim.f ====
hw/ipod_pkg.sv
hw/player_ctrl.sv
hw/speed_keys.sv
hw/sample_rate_gen.sv
hw/flash_fetch.sv
hw/sample_unpack.sv
hw/hex_display.sv
hw/ipod_top.sv
bench/flash_model.sv
bench/tb_ipod.sv
